// File: flist.f
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/pipeReg.sv
rtl/fetchUnit.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/hazardUnit.sv
rtl/pipeCore.sv
verif/pipeCore_props.sv
verif/pipeCore_tb.sv

// File: Makefile
# Verilator simulation of the pipelined core.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= pipeCore_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# The run passes only if the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/pipeCore_tb.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module pipeCore_tb;

  localparam int PROG_LEN       = 61;
  localparam int RESET_CYCLES   = 5;
  localparam int PARTIAL_CYCLES = 30;
  localparam int TIMEOUT_CYCLES = 5 * PROG_LEN + 50;
  localparam logic [31:0] SEED  = 32'd22;

  // Standard MIPS encodings of the kept subset.
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_ORI   = 6'h0D;
  localparam logic [5:0] OP_LUI   = 6'h0F;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2B;
  localparam logic [5:0] FN_ADDU  = 6'h21;
  localparam logic [5:0] FN_SUBU  = 6'h23;
  localparam logic [5:0] FN_AND   = 6'h24;
  localparam logic [5:0] FN_OR    = 6'h25;
  localparam logic [5:0] FN_SLT   = 6'h2A;

  logic                  CLK;
  logic                  nRST;
  logic [31:0]           imemAddr;
  logic [31:0]           imemData;
  logic [31:0]           dmemAddr;
  logic [31:0]           dmemWdata;
  logic                  dmemWen;
  logic                  dmemRen;
  logic [31:0]           dmemRdata;
  cpu_types_pkg::wbPortT retire;
  logic                  halted;

  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  logic [31:0] modelMem [64];
  logic [31:0] expReg [$];
  logic [31:0] expData [$];
  logic [31:0] rngState;
  int          retired;
  int          runCycles;

  pipeCore i_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .imemAddr  (imemAddr),
    .imemData  (imemData),
    .dmemAddr  (dmemAddr),
    .dmemWdata (dmemWdata),
    .dmemWen   (dmemWen),
    .dmemRen   (dmemRen),
    .dmemRdata (dmemRdata),
    .retire    (retire),
    .halted    (halted)
  );

  always #5 CLK = ~CLK;

  assign imemData  = imem[imemAddr[7:2]];

  // A read without the read strobe returns inverted data.
  assign dmemRdata = dmemRen ? dmem[dmemAddr[7:2]] : ~dmem[dmemAddr[7:2]];

  // Data memory is refilled while reset is held.
  always @(posedge CLK) begin
    if (!nRST) begin
      for (int w = 0; w < 64; w++) begin
        dmem[w] <= fillWord(w);
      end
    end else if (dmemWen) begin
      dmem[dmemAddr[7:2]] <= dmemWdata;
    end
  end

  always @(negedge CLK or negedge nRST) begin
    if (!nRST) begin
      runCycles <= 0;
    end else if (!halted) begin
      if (runCycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: halted never rose within %0d cycles after reset", TIMEOUT_CYCLES);
        abortRun();
      end else begin
        runCycles <= runCycles + 1;
      end
    end
  end

  function automatic logic [31:0] fillWord(input int idx);
    logic [15:0] addr;
    addr = 16'(idx * 4);
    return {addr ^ 16'hBEEF, ~addr};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int pickBelow(input int n);
    rngState = xorshift32(rngState);
    return int'(rngState % 32'(n));
  endfunction

  function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] fn);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic abortRun();
    $display("Errors found");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      abortRun();
    end
  endtask

  // Registers r0..r7 only, so dependencies between neighbours are frequent.
  task automatic buildProgram();
    int          kind;
    int          tgt;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      kind = pickBelow(13);
      rs   = 5'(pickBelow(8));
      rt   = 5'(pickBelow(8));
      rd   = 5'(pickBelow(8));
      imm  = 16'(pickBelow(65536));
      tgt  = i + 1 + pickBelow(4);
      if (tgt > PROG_LEN - 1) begin
        tgt = PROG_LEN - 1;
      end
      case (kind)
        0:       imem[i] = rtype(rs, rt, rd, FN_ADDU);
        1:       imem[i] = rtype(rs, rt, rd, FN_SUBU);
        2:       imem[i] = rtype(rs, rt, rd, FN_AND);
        3:       imem[i] = rtype(rs, rt, rd, FN_OR);
        4:       imem[i] = rtype(rs, rt, rd, FN_SLT);
        5:       imem[i] = itype(OP_ADDIU, rs, rt, imm);
        6:       imem[i] = itype(OP_ORI, rs, rt, imm);
        7:       imem[i] = itype(OP_LUI, 5'd0, rt, imm);
        8:       imem[i] = itype(OP_LW, 5'd0, rt, 16'(pickBelow(16) * 4));
        9:       imem[i] = itype(OP_SW, 5'd0, rt, 16'(pickBelow(16) * 4));
        10:      imem[i] = itype(OP_BEQ, rs, rt, 16'(tgt - i - 1));
        11:      imem[i] = itype(OP_BNE, rs, rt, 16'(tgt - i - 1));
        default: imem[i] = {OP_J, 26'(tgt)};
      endcase
    end
    imem[PROG_LEN - 1] = {`CPU_OP_HALT, 26'd0};
    // ORI into r0 is a no-op; its immediate carries the address.
    for (int i = PROG_LEN; i < 64; i++) begin
      imem[i] = itype(OP_ORI, 5'd0, 5'd0, 16'(i * 4));
    end
  endtask

  // Architectural model of the program, one instruction per step.
  task automatic runModel();
    logic [31:0] mreg [32];
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] res;
    logic [31:0] addr;
    logic [4:0]  dst;
    logic        wr;
    int          pc;
    for (int r = 0; r < 32; r++) begin
      mreg[r] = '0;
    end
    for (int w = 0; w < 64; w++) begin
      modelMem[w] = fillWord(w);
    end
    expReg.delete();
    expData.delete();
    pc = 0;
    while (imem[pc][31:26] != `CPU_OP_HALT) begin
      ins  = imem[pc];
      a    = mreg[ins[25:21]];
      b    = mreg[ins[20:16]];
      simm = {{16{ins[15]}}, ins[15:0]};
      addr = a + simm;
      dst  = ins[20:16];
      wr   = 1'b0;
      res  = '0;
      pc   = pc + 1;
      case (ins[31:26])
        OP_RTYPE: begin
          wr  = 1'b1;
          dst = ins[15:11];
          case (ins[5:0])
            FN_ADDU: res = a + b;
            FN_SUBU: res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          endcase
        end
        OP_ADDIU: begin
          wr  = 1'b1;
          res = a + simm;
        end
        OP_ORI: begin
          wr  = 1'b1;
          res = a | {16'd0, ins[15:0]};
        end
        OP_LUI: begin
          wr  = 1'b1;
          res = {ins[15:0], 16'd0};
        end
        OP_LW: begin
          wr  = 1'b1;
          res = modelMem[addr[7:2]];
        end
        OP_SW:  modelMem[addr[7:2]] = b;
        OP_BEQ: pc = (a == b) ? pc + $signed(simm) : pc;
        OP_BNE: pc = (a != b) ? pc + $signed(simm) : pc;
        OP_J:   pc = int'(ins[25:0]);
        default: ;
      endcase
      if (wr && dst != 5'd0) begin
        mreg[dst] = res;
        expReg.push_back(32'(dst));
        expData.push_back(res);
      end
    end
  endtask

  task automatic applyReset();
    @(negedge CLK);
    nRST = 1'b0;
    retired = 0;
    repeat (RESET_CYCLES) @(negedge CLK);
    checkEq(32'(halted), 32'd0, "halted while in reset");
    nRST = 1'b1;
    checkEq(imemAddr, `CPU_RESET_PC, "fetch address after reset");
  endtask

  // Each retire must be the next register write of the model.
  task automatic stepAndCheckRetire();
    @(negedge CLK);
    if (retire.valid) begin
      if (retired >= expReg.size()) begin
        $display("Core retired more than the %0d expected register writes", expReg.size());
        abortRun();
      end
      checkEq(32'(retire.regNum), expReg[retired], $sformatf("retire %0d register", retired));
      checkEq(retire.data, expData[retired], $sformatf("retire %0d data", retired));
      retired++;
    end
  endtask

  task automatic runToHalt();
    while (!halted) begin
      stepAndCheckRetire();
    end
  endtask

  task automatic checkAfterHalt();
    repeat (5) begin
      @(negedge CLK);
      checkEq(32'(retire.valid), 32'd0, "retire after halted");
      checkEq(32'(halted), 32'd1, "halted level after halt");
    end
    checkEq(32'(retired), 32'(expReg.size()), "number of retires");
    for (int w = 0; w < 64; w++) begin
      checkEq(dmem[w], modelMem[w], $sformatf("data memory word %0d", w));
    end
  endtask

  initial begin
    CLK      = 1'b0;
    nRST     = 1'b0;
    retired  = 0;
    rngState = SEED;
    buildProgram();
    runModel();

    applyReset();
    runToHalt();
    checkAfterHalt();

    // Reset out of halt, then again in the middle of the replay.
    applyReset();
    repeat (PARTIAL_CYCLES) stepAndCheckRetire();
    applyReset();
    runToHalt();
    checkAfterHalt();

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/pipeCore_props.sv
`timescale 1ns/100ps
`default_nettype none

module pipeCoreProps (
  input logic                  CLK,
  input logic                  nRST,
  input cpu_types_pkg::wbPortT retire,
  input logic                  dmemWen,
  input logic                  dmemRen,
  input logic                  halted
);

  // Nothing commits while the core is held in reset.
  noCommitInReset: assert property (@(posedge CLK) !nRST |-> !retire.valid && !dmemWen)
    else $error("retire or store seen during reset");

  noReadAndWrite: assert property (@(posedge CLK) disable iff (!nRST) !(dmemWen && dmemRen))
    else $error("data memory read and write in the same cycle");

  // Once set, halted only clears through reset.
  haltedSticky: assert property (@(posedge CLK) disable iff (!nRST) $past(halted) |-> halted)
    else $error("halted fell without a reset");

  noRetireToZero: assert property (@(posedge CLK) retire.valid |-> retire.regNum != '0)
    else $error("retire record names register zero");

endmodule

bind pipeCore pipeCoreProps i_props (
  .CLK     (CLK),
  .nRST    (nRST),
  .retire  (retire),
  .dmemWen (dmemWen),
  .dmemRen (dmemRen),
  .halted  (halted)
);

`default_nettype wire

// File: rtl/pipeCore.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module pipeCore (
  input  logic                  CLK,
  input  logic                  nRST,
  output logic [`CPU_XLEN-1:0]  imemAddr,
  input  logic [`CPU_XLEN-1:0]  imemData,
  output logic [`CPU_XLEN-1:0]  dmemAddr,
  output logic [`CPU_XLEN-1:0]  dmemWdata,
  output logic                  dmemWen,
  output logic                  dmemRen,
  input  logic [`CPU_XLEN-1:0]  dmemRdata,
  output cpu_types_pkg::wbPortT retire,
  output logic                  halted
);

  cpu_types_pkg::ifIdT   ifIdD;
  cpu_types_pkg::ifIdT   ifIdQ;
  cpu_types_pkg::idExT   idExD;
  cpu_types_pkg::idExT   idExQ;
  cpu_types_pkg::exMemT  exMemD;
  cpu_types_pkg::exMemT  exMemQ;
  cpu_types_pkg::memWbT  memWbD;
  cpu_types_pkg::memWbT  memWbQ;
  cpu_types_pkg::regIdxT idRs;
  cpu_types_pkg::regIdxT idRt;
  cpu_types_pkg::wordT   target;
  cpu_types_pkg::fwdSelT fwdA;
  cpu_types_pkg::fwdSelT fwdB;
  logic                  stall;
  logic                  redirect;
  logic                  flushIfId;
  logic                  flushIdEx;
  logic                  haltSeen;

  fetchUnit uFetch (
    .CLK      (CLK),
    .nRST     (nRST),
    .stall    (stall),
    .redirect (redirect),
    .target   (target),
    .haltSeen (haltSeen),
    .imemData (imemData),
    .pc       (imemAddr),
    .ifId     (ifIdD)
  );

  pipeReg #(.payloadT(cpu_types_pkg::ifIdT)) prIFID (
    .CLK(CLK), .nRST(nRST), .enable(~stall), .flush(flushIfId), .din(ifIdD), .dout(ifIdQ)
  );

  // The load flag is not needed here since the hazard unit sees ID/EX directly.
  decodeStage uDecode (
    .CLK      (CLK),
    .nRST     (nRST),
    .ifId     (ifIdQ),
    .memWb    (memWbQ),
    .idEx     (idExD),
    .rs       (idRs),
    .rt       (idRt),
    .isLoad   (),
    .haltSeen (haltSeen),
    .retire   (retire),
    .halted   (halted)
  );

  pipeReg #(.payloadT(cpu_types_pkg::idExT)) prIDEX (
    .CLK(CLK), .nRST(nRST), .enable(1'b1), .flush(flushIdEx), .din(idExD), .dout(idExQ)
  );

  // Writeback value reaches execute through the retire record.
  executeStage uExecute (
    .idEx     (idExQ),
    .fwdA     (fwdA),
    .fwdB     (fwdB),
    .exFwd    (exMemQ.aluResult),
    .wbFwd    (retire.data),
    .exMem    (exMemD),
    .redirect (redirect),
    .target   (target)
  );

  pipeReg #(.payloadT(cpu_types_pkg::exMemT)) prEXMEM (
    .CLK(CLK), .nRST(nRST), .enable(1'b1), .flush(1'b0), .din(exMemD), .dout(exMemQ)
  );

  assign dmemAddr  = exMemQ.aluResult;
  assign dmemWdata = exMemQ.storeData;
  assign dmemWen   = exMemQ.dWEN;
  assign dmemRen   = exMemQ.dREN;

  assign memWbD = '{wen: exMemQ.wen, memToReg: exMemQ.memToReg, halt: exMemQ.halt,
                    aluResult: exMemQ.aluResult, loadData: dmemRdata, dest: exMemQ.dest};

  pipeReg #(.payloadT(cpu_types_pkg::memWbT)) prMEMWB (
    .CLK(CLK), .nRST(nRST), .enable(1'b1), .flush(1'b0), .din(memWbD), .dout(memWbQ)
  );

  hazardUnit uHazard (
    .ifRs      (idRs),
    .ifRt      (idRt),
    .idEx      (idExQ),
    .exMem     (exMemQ),
    .memWb     (memWbQ),
    .redirect  (redirect),
    .stall     (stall),
    .flushIfId (flushIfId),
    .flushIdEx (flushIdEx),
    .fwdA      (fwdA),
    .fwdB      (fwdB)
  );

endmodule

`default_nettype wire

// File: rtl/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
  input  cpu_types_pkg::regIdxT ifRs,
  input  cpu_types_pkg::regIdxT ifRt,
  input  cpu_types_pkg::idExT   idEx,
  input  cpu_types_pkg::exMemT  exMem,
  input  cpu_types_pkg::memWbT  memWb,
  input  logic                  redirect,
  output logic                  stall,
  output logic                  flushIfId,
  output logic                  flushIdEx,
  output cpu_types_pkg::fwdSelT fwdA,
  output cpu_types_pkg::fwdSelT fwdB
);

  logic loadUse;

  // The younger producer in EX/MEM wins over MEM/WB.
  function automatic cpu_types_pkg::fwdSelT pickFwd(input cpu_types_pkg::regIdxT src);
    if (src == '0) begin
      return cpu_types_pkg::FWD_NONE;
    end
    if (exMem.wen && exMem.dest == src) begin
      return cpu_types_pkg::FWD_EXMEM;
    end
    if (memWb.wen && memWb.dest == src) begin
      return cpu_types_pkg::FWD_MEMWB;
    end
    return cpu_types_pkg::FWD_NONE;
  endfunction

  // Load in EX feeding the instruction in ID needs one bubble.
  assign loadUse = idEx.ctrl.dREN && (idEx.dest != '0) &&
                   ((idEx.dest == ifRs) || (idEx.dest == ifRt));

  assign stall     = loadUse;
  assign flushIfId = redirect;
  assign flushIdEx = redirect | loadUse;

  always_comb begin
    fwdA = pickFwd(idEx.rs);
    fwdB = pickFwd(idEx.rt);
  end

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module executeStage (
  input  cpu_types_pkg::idExT   idEx,
  input  cpu_types_pkg::fwdSelT fwdA,
  input  cpu_types_pkg::fwdSelT fwdB,
  input  cpu_types_pkg::wordT   exFwd,
  input  cpu_types_pkg::wordT   wbFwd,
  output cpu_types_pkg::exMemT  exMem,
  output logic                  redirect,
  output cpu_types_pkg::wordT   target
);

  cpu_types_pkg::wordT opA;
  cpu_types_pkg::wordT opB;
  cpu_types_pkg::wordT aluB;
  cpu_types_pkg::wordT aluResult;
  cpu_types_pkg::wordT branchTarget;
  cpu_types_pkg::wordT jumpTarget;
  logic                taken;

  always_comb begin
    case (fwdA)
      cpu_types_pkg::FWD_EXMEM: opA = exFwd;
      cpu_types_pkg::FWD_MEMWB: opA = wbFwd;
      default:                  opA = idEx.rdat1;
    endcase
    case (fwdB)
      cpu_types_pkg::FWD_EXMEM: opB = exFwd;
      cpu_types_pkg::FWD_MEMWB: opB = wbFwd;
      default:                  opB = idEx.rdat2;
    endcase
  end

  assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

  always_comb begin
    case (idEx.ctrl.aluOp)
      cpu_types_pkg::ALU_SUB: aluResult = opA - aluB;
      cpu_types_pkg::ALU_AND: aluResult = opA & aluB;
      cpu_types_pkg::ALU_OR:  aluResult = opA | aluB;
      cpu_types_pkg::ALU_SLT: aluResult = cpu_types_pkg::wordT'($signed(opA) < $signed(aluB));
      cpu_types_pkg::ALU_LUI: aluResult = {aluB[15:0], {(`CPU_XLEN-16){1'b0}}};
      default:                aluResult = opA + aluB;
    endcase
  end

  // BNE inverts the equality test.
  assign taken    = idEx.ctrl.branch & (idEx.ctrl.bne ^ (opA == opB));
  assign redirect = taken | idEx.ctrl.jmp;

  assign branchTarget = idEx.incPC + {idEx.imm[`CPU_XLEN-3:0], 2'b00};
  assign jumpTarget   = {idEx.incPC[`CPU_XLEN-1:`CPU_XLEN-4], idEx.imm[25:0], 2'b00};
  assign target       = idEx.ctrl.jmp ? jumpTarget : branchTarget;

  // Store data comes from the forwarded rt operand.
  assign exMem = '{wen: idEx.ctrl.wen, memToReg: idEx.ctrl.memToReg, dREN: idEx.ctrl.dREN,
                   dWEN: idEx.ctrl.dWEN, halt: idEx.ctrl.halt, aluResult: aluResult,
                   storeData: opB, dest: idEx.dest};

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  cpu_types_pkg::ifIdT   ifId,
  input  cpu_types_pkg::memWbT  memWb,
  output cpu_types_pkg::idExT   idEx,
  output cpu_types_pkg::regIdxT rs,
  output cpu_types_pkg::regIdxT rt,
  output logic                  isLoad,
  output logic                  haltSeen,
  output cpu_types_pkg::wbPortT retire,
  output logic                  halted
);

  cpu_types_pkg::wordT   instr;
  cpu_types_pkg::ctrlT   ctrl;
  cpu_types_pkg::wordT   rdat1;
  cpu_types_pkg::wordT   rdat2;
  cpu_types_pkg::wordT   imm;
  cpu_types_pkg::regIdxT dest;
  logic [15:0]           imm16;
  logic                  usesRs;
  logic                  usesRt;

  assign instr = ifId.instr;
  assign imm16 = instr[15:0];

  registerFile uRegs (
    .CLK    (CLK),
    .nRST   (nRST),
    .rs     (rs),
    .rt     (rt),
    .rdat1  (rdat1),
    .rdat2  (rdat2),
    .memWb  (memWb),
    .retire (retire),
    .halted (halted)
  );

  // Unknown opcodes and funct codes decode to a no-op.
  always_comb begin
    ctrl   = '0;
    usesRs = 1'b0;
    usesRt = 1'b0;
    case (instr[31:26])
      cpu_types_pkg::OP_RTYPE: begin
        usesRs      = 1'b1;
        usesRt      = 1'b1;
        ctrl.regDst = 1'b1;
        ctrl.wen    = 1'b1;
        case (instr[5:0])
          cpu_types_pkg::FN_ADDU: ctrl.aluOp = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::FN_SUBU: ctrl.aluOp = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::FN_AND:  ctrl.aluOp = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::FN_OR:   ctrl.aluOp = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::FN_SLT:  ctrl.aluOp = cpu_types_pkg::ALU_SLT;
          default:                ctrl.wen   = 1'b0;
        endcase
      end
      cpu_types_pkg::OP_ADDIU: begin
        usesRs      = 1'b1;
        ctrl.wen    = 1'b1;
        ctrl.aluSrc = 1'b1;
      end
      cpu_types_pkg::OP_ORI: begin
        usesRs       = 1'b1;
        ctrl.wen     = 1'b1;
        ctrl.aluSrc  = 1'b1;
        ctrl.zeroExt = 1'b1;
        ctrl.aluOp   = cpu_types_pkg::ALU_OR;
      end
      cpu_types_pkg::OP_LUI: begin
        ctrl.wen    = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = cpu_types_pkg::ALU_LUI;
      end
      cpu_types_pkg::OP_LW: begin
        usesRs        = 1'b1;
        ctrl.wen      = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.dREN     = 1'b1;
      end
      cpu_types_pkg::OP_SW: begin
        usesRs      = 1'b1;
        usesRt      = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.dWEN   = 1'b1;
      end
      cpu_types_pkg::OP_BEQ, cpu_types_pkg::OP_BNE: begin
        usesRs      = 1'b1;
        usesRt      = 1'b1;
        ctrl.branch = 1'b1;
        ctrl.bne    = instr[26];
        ctrl.aluOp  = cpu_types_pkg::ALU_SUB;
      end
      cpu_types_pkg::OP_J:    ctrl.jmp  = 1'b1;
      cpu_types_pkg::OP_HALT: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

  // Unused source fields read as r0 so they never match a hazard.
  assign rs = usesRs ? instr[25:21] : '0;
  assign rt = usesRt ? instr[20:16] : '0;

  assign dest = !ctrl.wen ? '0 : (ctrl.regDst ? instr[15:11] : instr[20:16]);

  // Jumps carry their 26-bit index in the immediate.
  always_comb begin
    if (ctrl.jmp) begin
      imm = {{(`CPU_XLEN-26){1'b0}}, instr[25:0]};
    end else if (ctrl.zeroExt) begin
      imm = {{(`CPU_XLEN-16){1'b0}}, imm16};
    end else begin
      imm = {{(`CPU_XLEN-16){imm16[15]}}, imm16};
    end
  end

  assign idEx = '{ctrl: ctrl, pc: ifId.pc, incPC: ifId.incPC, rdat1: rdat1, rdat2: rdat2,
                  imm: imm, rs: rs, rt: rt, dest: dest};

  assign isLoad   = ctrl.dREN;
  assign haltSeen = ctrl.halt;

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module registerFile (
  input  logic                  CLK,
  input  logic                  nRST,
  input  cpu_types_pkg::regIdxT rs,
  input  cpu_types_pkg::regIdxT rt,
  output cpu_types_pkg::wordT   rdat1,
  output cpu_types_pkg::wordT   rdat2,
  input  cpu_types_pkg::memWbT  memWb,
  output cpu_types_pkg::wbPortT retire,
  output logic                  halted
);

  // Register 0 has no storage.
  cpu_types_pkg::wordT regs [1:`CPU_NREGS-1];
  cpu_types_pkg::wordT wdata;
  logic                wrEn;
  logic                haltedQ;

  function automatic cpu_types_pkg::wordT readReg(input cpu_types_pkg::regIdxT idx);
    if (idx == '0) begin
      return '0;
    end
    // Same-cycle write is passed straight through.
    if (wrEn && idx == memWb.dest) begin
      return wdata;
    end
    return regs[idx];
  endfunction

  assign wdata = memWb.memToReg ? memWb.loadData : memWb.aluResult;
  assign wrEn  = memWb.wen && (memWb.dest != '0);

  // Architectural state restarts from zero on every reset.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
      haltedQ <= 1'b0;
    end else begin
      if (wrEn) begin
        regs[memWb.dest] <= wdata;
      end
      if (memWb.halt) begin
        haltedQ <= 1'b1;
      end
    end
  end

  always_comb begin
    rdat1 = readReg(rs);
    rdat2 = readReg(rt);
  end

  assign retire = '{valid: wrEn, regNum: memWb.dest, data: wdata};
  assign halted = haltedQ | memWb.halt;

endmodule

`default_nettype wire

// File: rtl/fetchUnit.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module fetchUnit (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                stall,
  input  logic                redirect,
  input  cpu_types_pkg::wordT target,
  input  logic                haltSeen,
  input  cpu_types_pkg::wordT imemData,
  output cpu_types_pkg::wordT pc,
  output cpu_types_pkg::ifIdT ifId
);

  cpu_types_pkg::wordT incPC;
  logic                frozen;
  logic                holdPC;

  assign incPC  = pc + `CPU_XLEN'd4;
  assign holdPC = stall | frozen | haltSeen;

  // A HALT that is squashed by an older taken branch must not freeze fetch.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc     <= `CPU_RESET_PC;
      frozen <= 1'b0;
    end else begin
      if (haltSeen && !redirect) begin
        frozen <= 1'b1;
      end
      if (redirect) begin
        pc <= target;
      end else if (!holdPC) begin
        pc <= incPC;
      end
    end
  end

  // Instructions behind a HALT enter decode as bubbles.
  always_comb begin
    ifId.instr = imemData;
    ifId.pc    = pc;
    ifId.incPC = incPC;
    if (frozen || haltSeen) begin
      ifId = '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/pipeReg.sv
`timescale 1ns/100ps
`default_nettype none

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    enable,
  input  logic    flush,
  input  payloadT din,
  output payloadT dout
);

  // An all-zero payload is a bubble.
  // Flush wins over enable so a stalled stage can still be squashed.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      dout <= '0;
    end else if (flush) begin
      dout <= '0;
    end else if (enable) begin
      dout <= din;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cpu_types_pkg.sv
`include "cpu_consts.svh"
`default_nettype none

package cpu_types_pkg;

  typedef logic [`CPU_XLEN-1:0] wordT;
  typedef logic [$clog2(`CPU_NREGS)-1:0] regIdxT;

  // Primary opcodes in instruction bits 31:26.
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0D,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B,
    OP_HALT  = `CPU_OP_HALT
  } opcodeT;

  // Function codes of the R-type instructions.
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2A
  } functT;

  // ALU_ADD is zero so that a bubble decodes to a harmless add.
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_SLT = 4'd4,
    ALU_LUI = 4'd5
  } aluOpT;

  // Operand source for the execute stage.
  typedef enum logic [1:0] {
    FWD_NONE  = 2'd0,
    FWD_EXMEM = 2'd1,
    FWD_MEMWB = 2'd2
  } fwdSelT;

  typedef struct packed {
    wordT instr;
    wordT pc;
    wordT incPC;
  } ifIdT;

  typedef struct packed {
    logic  wen;
    logic  regDst;
    logic  aluSrc;
    logic  memToReg;
    logic  dREN;
    logic  dWEN;
    logic  branch;
    logic  bne;
    logic  jmp;
    logic  zeroExt;
    logic  halt;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    ctrlT   ctrl;
    wordT   pc;
    wordT   incPC;
    wordT   rdat1;
    wordT   rdat2;
    wordT   imm;
    regIdxT rs;
    regIdxT rt;
    regIdxT dest;
  } idExT;

  typedef struct packed {
    logic   wen;
    logic   memToReg;
    logic   dREN;
    logic   dWEN;
    logic   halt;
    wordT   aluResult;
    wordT   storeData;
    regIdxT dest;
  } exMemT;

  typedef struct packed {
    logic   wen;
    logic   memToReg;
    logic   halt;
    wordT   aluResult;
    wordT   loadData;
    regIdxT dest;
  } memWbT;

  // One record per register write, in program order.
  typedef struct packed {
    logic   valid;
    regIdxT regNum;
    wordT   data;
  } wbPortT;

endpackage

`default_nettype wire

// File: rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Width of data words and byte addresses.
`define CPU_XLEN 32

// Architectural registers including the hardwired zero.
`define CPU_NREGS 32

// First fetch address after reset.
`define CPU_RESET_PC 32'h0000_0000

// Primary opcode that stops the core.
`define CPU_OP_HALT 6'h3F

`endif
